/* hw/axi_cplx_pkg.sv */
/* Widths, address map and encodings shared by the AXI subordinate complex
   Single-beat transfers only; the FIFO region offset is not decoded */
package axi_cplx_pkg;

    // Manager bus
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    // SRAM region, byte addressed
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
    localparam int SRAM_ADDR_W = 12;
    localparam int SRAM_WORDS  = 1024;

    // FIFO region, every offset hits the same port
    localparam logic [ADDR_W-1:0] FIFO_BASE = 32'h0001_0000;
    localparam int FIFO_ADDR_W = 12;
    localparam int FIFO_DEPTH  = 8;
    localparam int FIFO_CNT_W  = 4;

    // Reads or writes in flight per endpoint
    localparam int MAX_OUTSTANDING = 2;
    localparam int CNT_W           = 2;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axi_resp_e;

    // Address decode result
    typedef enum logic [1:0] {
        EP_SRAM,
        EP_FIFO,
        EP_NONE
    } ep_sel_e;

endpackage

/* hw/axi_txn_tracker.sv */
/* Outstanding read and write counters for one endpoint
   Counts saturate only through the full flags, which the crossbar honours */
`timescale 1ns/100ps

module axi_txn_tracker (
    input  logic                           core_clk,
    input  logic                           cptra_rst_b,
    input  logic                           i_ar_hs,
    input  logic                           i_r_hs,
    input  logic                           i_aw_hs,
    input  logic                           i_b_hs,
    output logic [axi_cplx_pkg::CNT_W-1:0] o_rd_cnt,
    output logic [axi_cplx_pkg::CNT_W-1:0] o_wr_cnt,
    output logic                           o_rd_full,
    output logic                           o_wr_full
);
    import axi_cplx_pkg::*;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            o_rd_cnt <= '0;
            o_wr_cnt <= '0;
        end else begin
            // Request and response in one cycle cancel out
            case ({i_ar_hs, i_r_hs})
                2'b10:   o_rd_cnt <= o_rd_cnt + 1'b1;
                2'b01:   o_rd_cnt <= o_rd_cnt - 1'b1;
                default: o_rd_cnt <= o_rd_cnt;
            endcase
            case ({i_aw_hs, i_b_hs})
                2'b10:   o_wr_cnt <= o_wr_cnt + 1'b1;
                2'b01:   o_wr_cnt <= o_wr_cnt - 1'b1;
                default: o_wr_cnt <= o_wr_cnt;
            endcase
        end
    end

    assign o_rd_full = (o_rd_cnt == CNT_W'(MAX_OUTSTANDING));
    assign o_wr_full = (o_wr_cnt == CNT_W'(MAX_OUTSTANDING));

endmodule

/* hw/axi_cplx_xbar.sv */
/* Address decode and response steering for one manager and two endpoints
   A request waits while any other source still owes responses on its channel
   Unmapped addresses are answered with DECERR and zero read data */
`timescale 1ns/100ps

module axi_cplx_xbar (
    input  logic core_clk,
    input  logic cptra_rst_b,
    // Manager port
    input  logic i_arvalid, i_rready, i_awvalid, i_bready,
    input  logic [axi_cplx_pkg::ADDR_W-1:0] i_araddr, i_awaddr,
    input  logic [axi_cplx_pkg::ID_W-1:0] i_arid, i_awid,
    input  logic [axi_cplx_pkg::DATA_W-1:0] i_wdata,
    input  logic [axi_cplx_pkg::STRB_W-1:0] i_wstrb,
    output logic o_arready, o_rvalid, o_awready, o_bvalid,
    output logic [axi_cplx_pkg::DATA_W-1:0] o_rdata,
    output axi_cplx_pkg::axi_resp_e o_rresp, o_bresp,
    output logic [axi_cplx_pkg::ID_W-1:0] o_rid, o_bid,
    // SRAM endpoint
    output logic o_sram_arvalid, o_sram_rready, o_sram_awvalid, o_sram_bready,
    output logic [axi_cplx_pkg::SRAM_ADDR_W-1:0] o_sram_araddr, o_sram_awaddr,
    output logic [axi_cplx_pkg::ID_W-1:0] o_sram_arid, o_sram_awid,
    output logic [axi_cplx_pkg::DATA_W-1:0] o_sram_wdata,
    output logic [axi_cplx_pkg::STRB_W-1:0] o_sram_wstrb,
    input  logic i_sram_arready, i_sram_rvalid, i_sram_awready, i_sram_bvalid,
    input  logic [axi_cplx_pkg::DATA_W-1:0] i_sram_rdata,
    input  axi_cplx_pkg::axi_resp_e i_sram_rresp, i_sram_bresp,
    input  logic [axi_cplx_pkg::ID_W-1:0] i_sram_rid, i_sram_bid,
    // FIFO endpoint
    output logic o_fifo_arvalid, o_fifo_rready, o_fifo_awvalid, o_fifo_bready,
    output logic [axi_cplx_pkg::FIFO_ADDR_W-1:0] o_fifo_araddr, o_fifo_awaddr,
    output logic [axi_cplx_pkg::ID_W-1:0] o_fifo_arid, o_fifo_awid,
    output logic [axi_cplx_pkg::DATA_W-1:0] o_fifo_wdata,
    output logic [axi_cplx_pkg::STRB_W-1:0] o_fifo_wstrb,
    input  logic i_fifo_arready, i_fifo_rvalid, i_fifo_awready, i_fifo_bvalid,
    input  logic [axi_cplx_pkg::DATA_W-1:0] i_fifo_rdata,
    input  axi_cplx_pkg::axi_resp_e i_fifo_rresp, i_fifo_bresp,
    input  logic [axi_cplx_pkg::ID_W-1:0] i_fifo_rid, i_fifo_bid
);
    import axi_cplx_pkg::*;

    ep_sel_e ar_sel, aw_sel, r_src, b_src;
    logic [CNT_W-1:0] sram_rd_cnt, sram_wr_cnt, fifo_rd_cnt, fifo_wr_cnt;
    logic sram_rd_full, sram_wr_full, fifo_rd_full, fifo_wr_full;
    logic sram_ar_ok, fifo_ar_ok, dec_ar_ok, sram_aw_ok, fifo_aw_ok, dec_aw_ok;
    logic dec_ar_hs, dec_aw_hs, dec_rvalid, dec_bvalid;
    logic [ID_W-1:0] dec_rid, dec_bid;

    function automatic ep_sel_e decode(input logic [ADDR_W-1:0] addr);
        if (addr[ADDR_W-1:SRAM_ADDR_W] == SRAM_BASE[ADDR_W-1:SRAM_ADDR_W]) begin
            return EP_SRAM;
        end
        if (addr[ADDR_W-1:FIFO_ADDR_W] == FIFO_BASE[ADDR_W-1:FIFO_ADDR_W]) begin
            return EP_FIFO;
        end
        return EP_NONE;
    endfunction

    assign ar_sel = decode(i_araddr);
    assign aw_sel = decode(i_awaddr);

    // Only one source can owe responses per channel, so it owns the mux
    assign r_src = (sram_rd_cnt != '0) ? EP_SRAM : (fifo_rd_cnt != '0) ? EP_FIFO : EP_NONE;
    assign b_src = (sram_wr_cnt != '0) ? EP_SRAM : (fifo_wr_cnt != '0) ? EP_FIFO : EP_NONE;

    // Ordering rule
    assign sram_ar_ok = (ar_sel == EP_SRAM) && !sram_rd_full && (fifo_rd_cnt == '0) && !dec_rvalid;
    assign fifo_ar_ok = (ar_sel == EP_FIFO) && !fifo_rd_full && (sram_rd_cnt == '0) && !dec_rvalid;
    assign dec_ar_ok  = (ar_sel == EP_NONE) && (r_src == EP_NONE) && (!dec_rvalid || i_rready);
    assign sram_aw_ok = (aw_sel == EP_SRAM) && !sram_wr_full && (fifo_wr_cnt == '0) && !dec_bvalid;
    assign fifo_aw_ok = (aw_sel == EP_FIFO) && !fifo_wr_full && (sram_wr_cnt == '0) && !dec_bvalid;
    assign dec_aw_ok  = (aw_sel == EP_NONE) && (b_src == EP_NONE) && (!dec_bvalid || i_bready);

    assign o_arready = (sram_ar_ok && i_sram_arready) || (fifo_ar_ok && i_fifo_arready) || dec_ar_ok;
    assign o_awready = (sram_aw_ok && i_sram_awready) || (fifo_aw_ok && i_fifo_awready) || dec_aw_ok;
    assign dec_ar_hs = i_arvalid && dec_ar_ok;
    assign dec_aw_hs = i_awvalid && dec_aw_ok;

    // Requests, with addresses cut to the region offset
    assign o_sram_arvalid = i_arvalid && sram_ar_ok;
    assign o_sram_araddr  = i_araddr[SRAM_ADDR_W-1:0];
    assign o_sram_arid    = i_arid;
    assign o_sram_awvalid = i_awvalid && sram_aw_ok;
    assign o_sram_awaddr  = i_awaddr[SRAM_ADDR_W-1:0];
    assign o_sram_awid    = i_awid;
    assign o_sram_wdata   = i_wdata;
    assign o_sram_wstrb   = i_wstrb;
    assign o_fifo_arvalid = i_arvalid && fifo_ar_ok;
    assign o_fifo_araddr  = i_araddr[FIFO_ADDR_W-1:0];
    assign o_fifo_arid    = i_arid;
    assign o_fifo_awvalid = i_awvalid && fifo_aw_ok;
    assign o_fifo_awaddr  = i_awaddr[FIFO_ADDR_W-1:0];
    assign o_fifo_awid    = i_awid;
    assign o_fifo_wdata   = i_wdata;
    assign o_fifo_wstrb   = i_wstrb;

    // Response mux
    assign o_sram_rready = i_rready && (r_src == EP_SRAM);
    assign o_fifo_rready = i_rready && (r_src == EP_FIFO);
    assign o_sram_bready = i_bready && (b_src == EP_SRAM);
    assign o_fifo_bready = i_bready && (b_src == EP_FIFO);

    assign o_rvalid = (r_src == EP_SRAM) ? i_sram_rvalid :
                      (r_src == EP_FIFO) ? i_fifo_rvalid : dec_rvalid;
    assign o_rdata  = (r_src == EP_SRAM) ? i_sram_rdata :
                      (r_src == EP_FIFO) ? i_fifo_rdata : '0;
    assign o_rresp  = (r_src == EP_SRAM) ? i_sram_rresp :
                      (r_src == EP_FIFO) ? i_fifo_rresp : RESP_DECERR;
    assign o_rid    = (r_src == EP_SRAM) ? i_sram_rid :
                      (r_src == EP_FIFO) ? i_fifo_rid : dec_rid;
    assign o_bvalid = (b_src == EP_SRAM) ? i_sram_bvalid :
                      (b_src == EP_FIFO) ? i_fifo_bvalid : dec_bvalid;
    assign o_bresp  = (b_src == EP_SRAM) ? i_sram_bresp :
                      (b_src == EP_FIFO) ? i_fifo_bresp : RESP_DECERR;
    assign o_bid    = (b_src == EP_SRAM) ? i_sram_bid :
                      (b_src == EP_FIFO) ? i_fifo_bid : dec_bid;

    // DECERR responder, one response slot per channel
    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            dec_rvalid <= 1'b0;
            dec_bvalid <= 1'b0;
        end else begin
            dec_rvalid <= dec_ar_hs || (dec_rvalid && !i_rready);
            dec_bvalid <= dec_aw_hs || (dec_bvalid && !i_bready);
        end
    end

    always_ff @(posedge core_clk) begin
        if (dec_ar_hs) begin
            dec_rid <= i_arid;
        end
        if (dec_aw_hs) begin
            dec_bid <= i_awid;
        end
    end

    axi_txn_tracker u_sram_trk (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .i_ar_hs     (o_sram_arvalid && i_sram_arready),
        .i_r_hs      (i_sram_rvalid && o_sram_rready),
        .i_aw_hs     (o_sram_awvalid && i_sram_awready),
        .i_b_hs      (i_sram_bvalid && o_sram_bready),
        .o_rd_cnt    (sram_rd_cnt),
        .o_wr_cnt    (sram_wr_cnt),
        .o_rd_full   (sram_rd_full),
        .o_wr_full   (sram_wr_full)
    );

    axi_txn_tracker u_fifo_trk (
        .core_clk    (core_clk),
        .cptra_rst_b (cptra_rst_b),
        .i_ar_hs     (o_fifo_arvalid && i_fifo_arready),
        .i_r_hs      (i_fifo_rvalid && o_fifo_rready),
        .i_aw_hs     (o_fifo_awvalid && i_fifo_awready),
        .i_b_hs      (i_fifo_bvalid && o_fifo_bready),
        .o_rd_cnt    (fifo_rd_cnt),
        .o_wr_cnt    (fifo_wr_cnt),
        .o_rd_full   (fifo_rd_full),
        .o_wr_full   (fifo_wr_full)
    );

endmodule

/* hw/axi_sram_sub.sv */
/* Single-beat SRAM subordinate, word indexed, byte strobes on writes
   Low address bits below the word are ignored; memory clears on reset */
`timescale 1ns/100ps

module axi_sram_sub (
    input  logic core_clk,
    input  logic cptra_rst_b,
    input  logic i_arvalid, i_rready, i_awvalid, i_bready,
    input  logic [axi_cplx_pkg::SRAM_ADDR_W-1:0] i_araddr, i_awaddr,
    input  logic [axi_cplx_pkg::ID_W-1:0] i_arid, i_awid,
    input  logic [axi_cplx_pkg::DATA_W-1:0] i_wdata,
    input  logic [axi_cplx_pkg::STRB_W-1:0] i_wstrb,
    output logic o_arready, o_rvalid, o_awready, o_bvalid,
    output logic [axi_cplx_pkg::DATA_W-1:0] o_rdata,
    output axi_cplx_pkg::axi_resp_e o_rresp, o_bresp,
    output logic [axi_cplx_pkg::ID_W-1:0] o_rid, o_bid
);
    import axi_cplx_pkg::*;

    logic [DATA_W-1:0] mem [SRAM_WORDS];
    logic [$clog2(SRAM_WORDS)-1:0] rd_idx, wr_idx;
    logic ar_hs, aw_hs;

    assign rd_idx = i_araddr[SRAM_ADDR_W-1:$clog2(STRB_W)];
    assign wr_idx = i_awaddr[SRAM_ADDR_W-1:$clog2(STRB_W)];

    // Accept when the response slot is free or draining
    assign o_arready = !o_rvalid || i_rready;
    assign o_awready = !o_bvalid || i_bready;
    assign ar_hs     = i_arvalid && o_arready;
    assign aw_hs     = i_awvalid && o_awready;

    assign o_rresp = RESP_OKAY;
    assign o_bresp = RESP_OKAY;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            o_rvalid <= 1'b0;
            o_bvalid <= 1'b0;
        end else begin
            o_rvalid <= ar_hs || (o_rvalid && !i_rready);
            o_bvalid <= aw_hs || (o_bvalid && !i_bready);
        end
    end

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            for (int w = 0; w < SRAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (aw_hs) begin
            // Merge only the strobed bytes
            for (int b = 0; b < STRB_W; b++) begin
                if (i_wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (ar_hs) begin
            o_rdata <= mem[rd_idx];
            o_rid   <= i_arid;
        end
        if (aw_hs) begin
            o_bid <= i_awid;
        end
    end

endmodule

/* hw/axi_fifo_sub.sv */
/* Word FIFO subordinate, writes push and reads pop regardless of offset
   Full push and empty pop answer SLVERR; write strobes are ignored */
`timescale 1ns/100ps

module axi_fifo_sub (
    input  logic core_clk,
    input  logic cptra_rst_b,
    input  logic i_arvalid, i_rready, i_awvalid, i_bready,
    input  logic [axi_cplx_pkg::FIFO_ADDR_W-1:0] i_araddr, i_awaddr,
    input  logic [axi_cplx_pkg::ID_W-1:0] i_arid, i_awid,
    input  logic [axi_cplx_pkg::DATA_W-1:0] i_wdata,
    input  logic [axi_cplx_pkg::STRB_W-1:0] i_wstrb,
    input  logic i_clear,
    output logic o_arready, o_rvalid, o_awready, o_bvalid,
    output logic [axi_cplx_pkg::DATA_W-1:0] o_rdata,
    output axi_cplx_pkg::axi_resp_e o_rresp, o_bresp,
    output logic [axi_cplx_pkg::ID_W-1:0] o_rid, o_bid,
    output logic o_avail
);
    import axi_cplx_pkg::*;

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr, rd_ptr;
    logic [FIFO_CNT_W-1:0] level;
    logic full, empty, ar_hs, aw_hs, push, pop;

    assign full  = (level == FIFO_CNT_W'(FIFO_DEPTH));
    assign empty = (level == '0);

    assign o_arready = !o_rvalid || i_rready;
    assign o_awready = !o_bvalid || i_bready;
    assign ar_hs     = i_arvalid && o_arready;
    assign aw_hs     = i_awvalid && o_awready;
    assign push      = aw_hs && !full;
    assign pop       = ar_hs && !empty;
    assign o_avail   = !empty;

    always_ff @(posedge core_clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            o_rvalid <= 1'b0;
            o_bvalid <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
        end else begin
            o_rvalid <= ar_hs || (o_rvalid && !i_rready);
            o_bvalid <= aw_hs || (o_bvalid && !i_bready);
            // Clear wins over a push or pop in the same cycle
            if (i_clear) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                level  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                level <= level + FIFO_CNT_W'(push) - FIFO_CNT_W'(pop);
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wdata;
        end
        if (ar_hs) begin
            o_rid   <= i_arid;
            o_rresp <= empty ? RESP_SLVERR : RESP_OKAY;
            o_rdata <= empty ? '0 : mem[rd_ptr];
        end
        if (aw_hs) begin
            o_bid   <= i_awid;
            o_bresp <= full ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

/* hw/axi_cplx_top.sv */
/* AXI subordinate complex with SRAM and FIFO endpoints behind one manager port
   Single-beat only; W travels with AW and shares its ready */
`timescale 1ns/100ps

module axi_cplx_top (
    input  logic core_clk,
    input  logic cptra_rst_b,
    input  logic i_arvalid, i_rready, i_awvalid, i_bready,
    input  logic [axi_cplx_pkg::ADDR_W-1:0] i_araddr, i_awaddr,
    input  logic [axi_cplx_pkg::ID_W-1:0] i_arid, i_awid,
    input  logic [axi_cplx_pkg::DATA_W-1:0] i_wdata,
    input  logic [axi_cplx_pkg::STRB_W-1:0] i_wstrb,
    output logic o_arready, o_rvalid, o_awready, o_bvalid,
    output logic [axi_cplx_pkg::DATA_W-1:0] o_rdata,
    output axi_cplx_pkg::axi_resp_e o_rresp, o_bresp,
    output logic [axi_cplx_pkg::ID_W-1:0] o_rid, o_bid,
    input  logic i_fifo_clear,
    output logic o_fifo_avail
);
    import axi_cplx_pkg::*;

    logic sram_arvalid, sram_arready, sram_rvalid, sram_rready;
    logic sram_awvalid, sram_awready, sram_bvalid, sram_bready;
    logic [SRAM_ADDR_W-1:0] sram_araddr, sram_awaddr;
    logic [ID_W-1:0] sram_arid, sram_rid, sram_awid, sram_bid;
    logic [DATA_W-1:0] sram_rdata, sram_wdata;
    logic [STRB_W-1:0] sram_wstrb;
    axi_resp_e sram_rresp, sram_bresp;

    logic fifo_arvalid, fifo_arready, fifo_rvalid, fifo_rready;
    logic fifo_awvalid, fifo_awready, fifo_bvalid, fifo_bready;
    logic [FIFO_ADDR_W-1:0] fifo_araddr, fifo_awaddr;
    logic [ID_W-1:0] fifo_arid, fifo_rid, fifo_awid, fifo_bid;
    logic [DATA_W-1:0] fifo_rdata, fifo_wdata;
    logic [STRB_W-1:0] fifo_wstrb;
    axi_resp_e fifo_rresp, fifo_bresp;

    // Manager side ports share names with the top level
    axi_cplx_xbar u_xbar (
        .*,
        .o_sram_arvalid(sram_arvalid), .o_sram_araddr(sram_araddr), .o_sram_arid(sram_arid),
        .o_sram_rready(sram_rready), .o_sram_awvalid(sram_awvalid),
        .o_sram_awaddr(sram_awaddr), .o_sram_awid(sram_awid), .o_sram_wdata(sram_wdata),
        .o_sram_wstrb(sram_wstrb), .o_sram_bready(sram_bready),
        .i_sram_arready(sram_arready), .i_sram_rvalid(sram_rvalid),
        .i_sram_rdata(sram_rdata), .i_sram_rresp(sram_rresp), .i_sram_rid(sram_rid),
        .i_sram_awready(sram_awready), .i_sram_bvalid(sram_bvalid),
        .i_sram_bresp(sram_bresp), .i_sram_bid(sram_bid),
        .o_fifo_arvalid(fifo_arvalid), .o_fifo_araddr(fifo_araddr), .o_fifo_arid(fifo_arid),
        .o_fifo_rready(fifo_rready), .o_fifo_awvalid(fifo_awvalid),
        .o_fifo_awaddr(fifo_awaddr), .o_fifo_awid(fifo_awid), .o_fifo_wdata(fifo_wdata),
        .o_fifo_wstrb(fifo_wstrb), .o_fifo_bready(fifo_bready),
        .i_fifo_arready(fifo_arready), .i_fifo_rvalid(fifo_rvalid),
        .i_fifo_rdata(fifo_rdata), .i_fifo_rresp(fifo_rresp), .i_fifo_rid(fifo_rid),
        .i_fifo_awready(fifo_awready), .i_fifo_bvalid(fifo_bvalid),
        .i_fifo_bresp(fifo_bresp), .i_fifo_bid(fifo_bid)
    );

    axi_sram_sub u_sram (
        .core_clk(core_clk), .cptra_rst_b(cptra_rst_b),
        .i_arvalid(sram_arvalid), .i_araddr(sram_araddr), .i_arid(sram_arid),
        .o_arready(sram_arready), .i_rready(sram_rready), .o_rvalid(sram_rvalid),
        .o_rdata(sram_rdata), .o_rresp(sram_rresp), .o_rid(sram_rid),
        .i_awvalid(sram_awvalid), .i_awaddr(sram_awaddr), .i_awid(sram_awid),
        .i_wdata(sram_wdata), .i_wstrb(sram_wstrb), .o_awready(sram_awready),
        .i_bready(sram_bready), .o_bvalid(sram_bvalid), .o_bresp(sram_bresp),
        .o_bid(sram_bid)
    );

    axi_fifo_sub u_fifo (
        .core_clk(core_clk), .cptra_rst_b(cptra_rst_b),
        .i_arvalid(fifo_arvalid), .i_araddr(fifo_araddr), .i_arid(fifo_arid),
        .o_arready(fifo_arready), .i_rready(fifo_rready), .o_rvalid(fifo_rvalid),
        .o_rdata(fifo_rdata), .o_rresp(fifo_rresp), .o_rid(fifo_rid),
        .i_awvalid(fifo_awvalid), .i_awaddr(fifo_awaddr), .i_awid(fifo_awid),
        .i_wdata(fifo_wdata), .i_wstrb(fifo_wstrb), .o_awready(fifo_awready),
        .i_bready(fifo_bready), .o_bvalid(fifo_bvalid), .o_bresp(fifo_bresp),
        .o_bid(fifo_bid), .i_clear(i_fifo_clear), .o_avail(o_fifo_avail)
    );

endmodule

/* sim/axi_cplx_tb.sv */
/* Testbench for the AXI subordinate complex, checked against a behavioural model
   Stimulus comes from a 16-bit Galois LFSR; responses are matched in request order */
`timescale 1ns/100ps

module axi_cplx_tb;
    import axi_cplx_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int N_SRAM     = 16;
    localparam int N_FIFO_WR  = FIFO_DEPTH + 2;
    localparam int N_FIFO_RD  = FIFO_DEPTH + 1;
    localparam int N_MIXED    = 300;
    localparam int TOTAL_OPS  = 2 * N_SRAM + N_FIFO_WR + N_FIFO_RD + 2 + N_MIXED + 4;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

    logic core_clk;
    logic cptra_rst_b;
    logic arvalid, rready, awvalid, bready, fifo_clear;
    logic [ADDR_W-1:0] araddr, awaddr;
    logic [ID_W-1:0] arid, awid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic arready, rvalid, awready, bvalid, fifo_avail;
    logic [DATA_W-1:0] rdata;
    axi_resp_e rresp, bresp;
    logic [ID_W-1:0] rid, bid;

    // Pending request slots applied on the next falling edge
    logic ar_busy, aw_busy, bp_mode, clear_req;
    logic [ADDR_W-1:0] ar_addr, aw_addr;
    logic [ID_W-1:0] ar_id, aw_id;
    logic [DATA_W-1:0] aw_data;
    logic [STRB_W-1:0] aw_strb;
    logic [15:0] lfsr;

    // Reference model state
    logic [DATA_W-1:0] sram_model [SRAM_WORDS];
    logic [DATA_W-1:0] fifo_model [$];
    logic [DATA_W-1:0] exp_rdata [$];
    logic [1:0] exp_rresp [$];
    logic [1:0] exp_bresp [$];
    logic [ID_W-1:0] exp_rid [$];
    logic [ID_W-1:0] exp_bid [$];

    axi_cplx_top u_axi_cplx_top (
        .core_clk(core_clk), .cptra_rst_b(cptra_rst_b),
        .i_arvalid(arvalid), .i_araddr(araddr), .i_arid(arid), .o_arready(arready),
        .i_rready(rready), .o_rvalid(rvalid), .o_rdata(rdata), .o_rresp(rresp),
        .o_rid(rid), .i_awvalid(awvalid), .i_awaddr(awaddr), .i_awid(awid),
        .i_wdata(wdata), .i_wstrb(wstrb), .o_awready(awready), .i_bready(bready),
        .o_bvalid(bvalid), .o_bresp(bresp), .o_bid(bid),
        .i_fifo_clear(fifo_clear), .o_fifo_avail(fifo_avail)
    );

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic check_hex(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            stop_on_failure();
        end
    endtask

    // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic in_region(input logic [ADDR_W-1:0] addr,
                                       input logic [ADDR_W-1:0] base, input int width);
        return (addr >= base) && (addr < base + (1 << width));
    endfunction

    task automatic model_read(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id);
        logic [SRAM_IDX_W-1:0] idx;
        idx = addr[SRAM_ADDR_W-1:$clog2(STRB_W)];
        if (in_region(addr, SRAM_BASE, SRAM_ADDR_W)) begin
            exp_rdata.push_back(sram_model[idx]);
            exp_rresp.push_back(RESP_OKAY);
        end else if (in_region(addr, FIFO_BASE, FIFO_ADDR_W)) begin
            if (fifo_model.size() == 0) begin
                exp_rdata.push_back('0);
                exp_rresp.push_back(RESP_SLVERR);
            end else begin
                exp_rdata.push_back(fifo_model.pop_front());
                exp_rresp.push_back(RESP_OKAY);
            end
        end else begin
            exp_rdata.push_back('0);
            exp_rresp.push_back(RESP_DECERR);
        end
        exp_rid.push_back(id);
    endtask

    // Full is judged before any pop in the same cycle
    task automatic model_write(input logic was_full);
        logic [SRAM_IDX_W-1:0] idx;
        idx = awaddr[SRAM_ADDR_W-1:$clog2(STRB_W)];
        if (in_region(awaddr, SRAM_BASE, SRAM_ADDR_W)) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) begin
                    sram_model[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            exp_bresp.push_back(RESP_OKAY);
        end else if (in_region(awaddr, FIFO_BASE, FIFO_ADDR_W)) begin
            if (was_full) begin
                exp_bresp.push_back(RESP_SLVERR);
            end else begin
                fifo_model.push_back(wdata);
                exp_bresp.push_back(RESP_OKAY);
            end
        end else begin
            exp_bresp.push_back(RESP_DECERR);
        end
        exp_bid.push_back(awid);
    endtask

    task automatic check_read_resp();
        assert (exp_rid.size() != 0) else begin
            $display("Read response arrived with no read outstanding at %0t", $time);
            stop_on_failure();
        end
        check_hex("o_rid", rid, exp_rid.pop_front());
        check_hex("o_rresp", rresp, exp_rresp.pop_front());
        check_hex("o_rdata", rdata, exp_rdata.pop_front());
    endtask

    task automatic check_write_resp();
        assert (exp_bid.size() != 0) else begin
            $display("Write response arrived with no write outstanding at %0t", $time);
            stop_on_failure();
        end
        check_hex("o_bid", bid, exp_bid.pop_front());
        check_hex("o_bresp", bresp, exp_bresp.pop_front());
    endtask

    // Drive on the falling edge and judge the coming rising edge
    task automatic cycle();
        logic was_full, rd_idle, wr_idle;
        @(negedge core_clk);
        arvalid    = ar_busy;
        araddr     = ar_addr;
        arid       = ar_id;
        awvalid    = aw_busy;
        awaddr     = aw_addr;
        awid       = aw_id;
        wdata      = aw_data;
        wstrb      = aw_strb;
        rready     = bp_mode ? (take_bits(2) != 0) : 1'b1;
        bready     = bp_mode ? (take_bits(2) != 0) : 1'b1;
        fifo_clear = clear_req;
        #1;
        check_hex("o_fifo_avail", fifo_avail, fifo_model.size() != 0);
        was_full = (fifo_model.size() == FIFO_DEPTH);
        rd_idle  = (exp_rid.size() == 0);
        wr_idle  = (exp_bid.size() == 0);
        // Nothing owed on the channel, so a request goes through at once
        if (arvalid && rd_idle) begin
            check_hex("o_arready", arready, 1);
        end
        if (awvalid && wr_idle) begin
            check_hex("o_awready", awready, 1);
        end
        if (rvalid && rready) begin
            check_read_resp();
        end
        if (bvalid && bready) begin
            check_write_resp();
        end
        if (arvalid && arready) begin
            model_read(araddr, arid);
            ar_busy = 1'b0;
        end
        if (awvalid && awready) begin
            model_write(was_full);
            aw_busy = 1'b0;
        end
        if (clear_req) begin
            fifo_model.delete();
            clear_req = 1'b0;
        end
    endtask

    task automatic send_read(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id);
        while (ar_busy) begin
            cycle();
        end
        ar_addr = addr;
        ar_id   = id;
        ar_busy = 1'b1;
    endtask

    task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                              input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        while (aw_busy) begin
            cycle();
        end
        aw_addr = addr;
        aw_id   = id;
        aw_data = data;
        aw_strb = strb;
        aw_busy = 1'b1;
    endtask

    task automatic drain();
        while (ar_busy || aw_busy || exp_rid.size() != 0 || exp_bid.size() != 0) begin
            cycle();
        end
    endtask

    // SRAM hits stay in the first 16 words so later writes merge over earlier ones
    function automatic logic [ADDR_W-1:0] rand_addr(input logic [1:0] region);
        case (region)
            2'd0, 2'd1: return SRAM_BASE + take_bits(6);
            2'd2:       return FIFO_BASE + take_bits(FIFO_ADDR_W);
            default:    return 32'h8000_0000 | take_bits(16);
        endcase
    endfunction

    initial begin
        #(TOTAL_OPS * 20 * CLK_PERIOD);
        $display("Timeout: responses stopped arriving before the tests finished");
        stop_on_failure();
    end

    initial begin
        logic [1:0] region;
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0] id;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        core_clk    = 1'b0;
        cptra_rst_b = 1'b0;
        {arvalid, rready, awvalid, bready, fifo_clear} = '0;
        {araddr, awaddr, arid, awid, wdata, wstrb} = '0;
        {ar_busy, aw_busy, bp_mode, clear_req} = '0;
        {ar_addr, aw_addr, ar_id, aw_id, aw_data, aw_strb} = '0;
        lfsr = 16'd61636;
        for (int w = 0; w < SRAM_WORDS; w++) begin
            sram_model[w] = '0;
        end
        repeat (5) @(posedge core_clk);
        @(negedge core_clk);
        cptra_rst_b = 1'b1;
        #1;
        check_hex("o_rvalid", rvalid, 0);
        check_hex("o_bvalid", bvalid, 0);
        check_hex("o_fifo_avail", fifo_avail, 0);

        // SRAM writes with random strobes, then read back
        for (int i = 0; i < N_SRAM; i++) begin
            id   = take_bits(ID_W);
            data = take_bits(DATA_W);
            strb = take_bits(STRB_W);
            send_write(SRAM_BASE + 4 * i, id, data, strb);
        end
        for (int i = 0; i < N_SRAM; i++) begin
            id = take_bits(ID_W);
            send_read(SRAM_BASE + 4 * i, id);
        end
        drain();

        // FIFO past full, then past empty
        for (int i = 0; i < N_FIFO_WR; i++) begin
            id   = take_bits(ID_W);
            data = take_bits(DATA_W);
            send_write(FIFO_BASE + 4 * i, id, data, '1);
        end
        drain();
        for (int i = 0; i < N_FIFO_RD; i++) begin
            id = take_bits(ID_W);
            send_read(FIFO_BASE, id);
        end
        drain();

        // Unmapped addresses
        send_read(32'h0002_0000, take_bits(ID_W));
        send_write(32'hFFFF_FFF0, take_bits(ID_W), 32'hDEAD_BEEF, '1);
        drain();

        // Mixed stream with random back-pressure
        bp_mode = 1'b1;
        for (int i = 0; i < N_MIXED; i++) begin
            region = take_bits(2);
            addr   = rand_addr(region);
            id     = take_bits(ID_W);
            if (take_bits(1)) begin
                send_read(addr, id);
            end else begin
                data = take_bits(DATA_W);
                strb = take_bits(STRB_W);
                send_write(addr, id, data, strb);
            end
        end
        drain();
        bp_mode = 1'b0;

        // FIFO clear with data stored and nothing in flight
        send_write(FIFO_BASE, take_bits(ID_W), take_bits(DATA_W), '1);
        send_write(FIFO_BASE, take_bits(ID_W), take_bits(DATA_W), '1);
        drain();
        clear_req = 1'b1;
        cycle();
        cycle();
        check_hex("o_fifo_avail", fifo_avail, 0);
        send_read(FIFO_BASE, take_bits(ID_W));
        drain();

        // A repeated or late response would show up in this idle cycle
        cycle();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* sources.f */
hw/axi_cplx_pkg.sv
hw/axi_txn_tracker.sv
hw/axi_cplx_xbar.sv
hw/axi_sram_sub.sv
hw/axi_fifo_sub.sv
hw/axi_cplx_top.sv
sim/axi_cplx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module axi_cplx_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vaxi_cplx_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
